/* addr_decoder.sv */
// ##############################
// Address decoder: picks the target window
// for one master, error target by default
// ##############################
`default_nettype none

module addr_decoder
  import xbar_pkg::*;
(
  input  logic [ADDR_W-1:0]     addr_i,
  output logic [LOG_NSLAVE-1:0] idx_o
);

  always_comb begin
    logic [ADDR_W-1:0] offset;
    offset = '0;
    // Unmapped addresses fall through to the error target
    idx_o = LOG_NSLAVE'(ERROR_IDX);
    for (int s = 0; s < NEXT_SLAVE; s++) begin
      // Offset compare stays correct near the top of the address space
      offset = addr_i - SLV_BASE[s];
      if (offset < SLV_SIZE[s]) begin
        idx_o = LOG_NSLAVE'(s);
      end
    end
  end

endmodule : addr_decoder

`default_nettype wire

/* build.f */
xbar_pkg.sv
addr_decoder.sv
rr_arbiter.sv
xbar_varlat.sv
error_slave.sv
system_xbar.sv
system_xbar_sva.sv
tb_slave_model.sv
tb_system_xbar.sv

/* error_slave.sv */
// ##############################
// Error target: grants at once and answers
// every unmapped access with the error word
// ##############################
`default_nettype none

module error_slave
  import xbar_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic rvalid_q;

  // Never stalls
  assign gnt_o = req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      // One response per transfer in the next cycle
      rvalid_q <= req_i;
    end
  end

  // Reads and writes alike complete with the error word
  assign rvalid_o = rvalid_q;
  assign rdata_o  = ERR_RDATA;

endmodule : error_slave

`default_nettype wire

/* rr_arbiter.sv */
// ##############################
// Round-robin arbiter for one target
// ##############################
`default_nettype none

module rr_arbiter
  import xbar_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NMASTER-1:0]     req_i,
  input  logic                   advance_i,
  output logic [NMASTER-1:0]     grant_o,
  output logic [LOG_NMASTER-1:0] grant_idx_o
);

  // Master with highest priority in the next arbitration
  logic [LOG_NMASTER-1:0] ptr_q;

  always_comb begin
    int   cand;
    logic found;
    cand        = 0;
    found       = 1'b0;
    grant_o     = '0;
    grant_idx_o = '0;
    // Scan from the pointer, wrapping once around the masters
    for (int k = 0; k < NMASTER; k++) begin
      cand = int'(ptr_q) + k;
      if (cand >= NMASTER) begin
        cand = cand - NMASTER;
      end
      if (!found && req_i[cand]) begin
        found         = 1'b1;
        grant_o[cand] = 1'b1;
        grant_idx_o   = LOG_NMASTER'(cand);
      end
    end
  end

  // Move past the winner only once its transfer is done
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i) begin
      if (grant_idx_o == LOG_NMASTER'(NMASTER - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_idx_o + 1'b1;
      end
    end
  end

endmodule : rr_arbiter

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_system_xbar
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_system_xbar)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

/* system_xbar.sv */
// ##############################
// System bus crossbar: two masters to ROM,
// RAM, peripherals and the error target
// ##############################
`default_nettype none

module system_xbar
  import xbar_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Masters
  input  logic [NMASTER-1:0]                  master_req_i,
  input  logic [NMASTER-1:0]                  master_we_i,
  input  logic [NMASTER-1:0][BE_W-1:0]        master_be_i,
  input  logic [NMASTER-1:0][ADDR_W-1:0]      master_addr_i,
  input  logic [NMASTER-1:0][DATA_W-1:0]      master_wdata_i,
  output logic [NMASTER-1:0]                  master_gnt_o,
  output logic [NMASTER-1:0]                  master_rvalid_o,
  output logic [NMASTER-1:0][DATA_W-1:0]      master_rdata_o,
  // External targets
  output logic [NEXT_SLAVE-1:0]               slave_req_o,
  output logic [NEXT_SLAVE-1:0]               slave_we_o,
  output logic [NEXT_SLAVE-1:0][BE_W-1:0]     slave_be_o,
  output logic [NEXT_SLAVE-1:0][ADDR_W-1:0]   slave_addr_o,
  output logic [NEXT_SLAVE-1:0][DATA_W-1:0]   slave_wdata_o,
  input  logic [NEXT_SLAVE-1:0]               slave_gnt_i,
  input  logic [NEXT_SLAVE-1:0]               slave_rvalid_i,
  input  logic [NEXT_SLAVE-1:0][DATA_W-1:0]   slave_rdata_i
);

  logic [NMASTER-1:0][LOG_NSLAVE-1:0] port_sel;

  // All target ports of the crossbar, error target included
  logic [NSLAVE-1:0]             xs_req;
  logic [NSLAVE-1:0]             xs_we;
  logic [NSLAVE-1:0][BE_W-1:0]   xs_be;
  logic [NSLAVE-1:0][ADDR_W-1:0] xs_addr;
  logic [NSLAVE-1:0][DATA_W-1:0] xs_wdata;
  logic [NSLAVE-1:0]             xs_gnt;
  logic [NSLAVE-1:0]             xs_rvalid;
  logic [NSLAVE-1:0][DATA_W-1:0] xs_rdata;

  for (genvar m = 0; m < NMASTER; m++) begin : gen_dec
    addr_decoder i_dec (
      .addr_i(master_addr_i[m]),
      .idx_o (port_sel[m])
    );
  end

  xbar_varlat i_xbar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (master_req_i),
    .sel_i   (port_sel),
    .we_i    (master_we_i),
    .be_i    (master_be_i),
    .addr_i  (master_addr_i),
    .wdata_i (master_wdata_i),
    .gnt_o   (master_gnt_o),
    .rvalid_o(master_rvalid_o),
    .rdata_o (master_rdata_o),
    .req_o   (xs_req),
    .we_o    (xs_we),
    .be_o    (xs_be),
    .addr_o  (xs_addr),
    .wdata_o (xs_wdata),
    .gnt_i   (xs_gnt),
    .rvalid_i(xs_rvalid),
    .rdata_i (xs_rdata)
  );

  error_slave i_err (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (xs_req[ERROR_IDX]),
    .we_i    (xs_we[ERROR_IDX]),
    .gnt_o   (xs_gnt[ERROR_IDX]),
    .rvalid_o(xs_rvalid[ERROR_IDX]),
    .rdata_o (xs_rdata[ERROR_IDX])
  );

  // Ports 0 to 2 leave the crossbar
  assign slave_req_o   = xs_req[NEXT_SLAVE-1:0];
  assign slave_we_o    = xs_we[NEXT_SLAVE-1:0];
  assign slave_be_o    = xs_be[NEXT_SLAVE-1:0];
  assign slave_addr_o  = xs_addr[NEXT_SLAVE-1:0];
  assign slave_wdata_o = xs_wdata[NEXT_SLAVE-1:0];

  assign xs_gnt[NEXT_SLAVE-1:0]    = slave_gnt_i;
  assign xs_rvalid[NEXT_SLAVE-1:0] = slave_rvalid_i;
  assign xs_rdata[NEXT_SLAVE-1:0]  = slave_rdata_i;

endmodule : system_xbar

`default_nettype wire

/* system_xbar_sva.sv */
// ##############################
// Protocol and routing assertions,
// bound into the crossbar top level
// ##############################
`default_nettype none

module system_xbar_sva
  import xbar_pkg::*;
(
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic [NMASTER-1:0]                master_req_i,
  input logic [NMASTER-1:0]                master_we_i,
  input logic [NMASTER-1:0][BE_W-1:0]      master_be_i,
  input logic [NMASTER-1:0][ADDR_W-1:0]    master_addr_i,
  input logic [NMASTER-1:0][DATA_W-1:0]    master_wdata_i,
  input logic [NMASTER-1:0]                master_gnt_i,
  input logic [NMASTER-1:0]                master_rvalid_i,
  input logic [NMASTER-1:0][DATA_W-1:0]    master_rdata_i,
  input logic [NEXT_SLAVE-1:0]             slave_req_i,
  input logic                              err_rvalid_i
);

  int fail_cnt = 0;
  logic [NEXT_SLAVE-1:0] demand;
  logic [NMASTER-1:0]    err_rsp;

  // Targets that some master is asking for right now
  always_comb begin
    demand = '0;
    for (int m = 0; m < NMASTER; m++) begin
      for (int s = 0; s < NEXT_SLAVE; s++) begin
        if (master_req_i[m] && master_addr_i[m] >= SLV_BASE[s] &&
            master_addr_i[m] < SLV_BASE[s] + SLV_SIZE[s]) begin
          demand[s] = 1'b1;
        end
      end
    end
  end

  // Masters that receive the error word in this cycle
  always_comb begin
    err_rsp = '0;
    for (int m = 0; m < NMASTER; m++) begin
      err_rsp[m] = master_rvalid_i[m] && (master_rdata_i[m] == ERR_RDATA);
    end
  end

  a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (master_gnt_i & ~master_req_i) == '0)
    else begin $error("grant without request"); fail_cnt++; end

  for (genvar m = 0; m < NMASTER; m++) begin : gen_stable
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      master_req_i[m] && !master_gnt_i[m] |=> master_req_i[m] &&
      $stable(master_we_i[m]) && $stable(master_be_i[m]) &&
      $stable(master_addr_i[m]) && $stable(master_wdata_i[m]))
      else begin $error("request changed before grant"); fail_cnt++; end
  end

  a_slave_req_decoded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slave_req_i & ~demand) == '0)
    else begin $error("target request without decoded master"); fail_cnt++; end

  a_err_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_rvalid_i |-> err_rsp != '0)
    else begin $error("error response not delivered with the error word"); fail_cnt++; end

endmodule : system_xbar_sva

bind system_xbar system_xbar_sva i_sva (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .master_req_i   (master_req_i),
  .master_we_i    (master_we_i),
  .master_be_i    (master_be_i),
  .master_addr_i  (master_addr_i),
  .master_wdata_i (master_wdata_i),
  .master_gnt_i   (master_gnt_o),
  .master_rvalid_i(master_rvalid_o),
  .master_rdata_i (master_rdata_o),
  .slave_req_i    (slave_req_o),
  .err_rvalid_i   (xs_rvalid[ERROR_IDX])
);

`default_nettype wire

/* tb_slave_model.sv */
// ##############################
// Memory target model with random grant
// stalls and in-order delayed responses
// ##############################
`default_nettype none

module tb_slave_model
  import xbar_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h192e_bf8a
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem [1024];
  logic [31:0]       lfsr_q;
  logic              stall_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rsp_data [$];
  int unsigned       rsp_due [$];
  int unsigned       cyc;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = '0;
    end
  end

  assign gnt_o    = req_i && !stall_q;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  always @(posedge clk_i) begin
    logic [31:0]       s;
    logic [1:0]        stall_bits;
    logic [1:0]        dly;
    logic [DATA_W-1:0] word;
    logic [9:0]        idx;
    if (!rst_n_i) begin
      lfsr_q   <= SEED;
      stall_q  <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      cyc      = 0;
      rsp_data.delete();
      rsp_due.delete();
    end else begin
      cyc = cyc + 1;
      s = lfsr_q;
      // Oldest response leaves first once its delay is over
      if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end else begin
        rvalid_q <= 1'b0;
      end
      if (req_i && gnt_o) begin
        s = lfsr_step(s);
        dly[0] = s[0];
        s = lfsr_step(s);
        dly[1] = s[0];
        idx  = addr_i[11:2];
        word = mem[idx];
        rsp_data.push_back(word);
        rsp_due.push_back(cyc + {30'b0, dly});
        if (we_i) begin
          for (int b = 0; b < BE_W; b++) begin
            if (be_i[b]) begin
              word[8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          mem[idx] = word;
        end
      end
      // Grant withheld on about one cycle in four
      s = lfsr_step(s);
      stall_bits[0] = s[0];
      s = lfsr_step(s);
      stall_bits[1] = s[0];
      stall_q <= &stall_bits;
      lfsr_q  <= s;
    end
  end

endmodule : tb_slave_model

`default_nettype wire

/* tb_system_xbar.sv */
// ##############################
// Testbench for the system bus crossbar
// ##############################
`default_nettype none

module tb_system_xbar
  import xbar_pkg::*;
;

  // All tests together take a few hundred cycles
  localparam int MAX_CYCLES = 4000;

  logic clk_i;
  logic rst_n_i;
  logic [NMASTER-1:0]                master_req_i;
  logic [NMASTER-1:0]                master_we_i;
  logic [NMASTER-1:0][BE_W-1:0]      master_be_i;
  logic [NMASTER-1:0][ADDR_W-1:0]    master_addr_i;
  logic [NMASTER-1:0][DATA_W-1:0]    master_wdata_i;
  logic [NMASTER-1:0]                master_gnt_o;
  logic [NMASTER-1:0]                master_rvalid_o;
  logic [NMASTER-1:0][DATA_W-1:0]    master_rdata_o;
  logic [NEXT_SLAVE-1:0]             slave_req_o;
  logic [NEXT_SLAVE-1:0]             slave_we_o;
  logic [NEXT_SLAVE-1:0][BE_W-1:0]   slave_be_o;
  logic [NEXT_SLAVE-1:0][ADDR_W-1:0] slave_addr_o;
  logic [NEXT_SLAVE-1:0][DATA_W-1:0] slave_wdata_o;
  logic [NEXT_SLAVE-1:0]             slave_gnt_i;
  logic [NEXT_SLAVE-1:0]             slave_rvalid_i;
  logic [NEXT_SLAVE-1:0][DATA_W-1:0] slave_rdata_i;

  int errors = 0;
  int tests = 0;
  int cycles = 0;
  int contended = 0;
  int last_win [NEXT_SLAVE];
  logic err_phase = 1'b0;
  // Bit 32 set means the response data is checked
  logic [32:0] exp_q0 [$];
  logic [32:0] exp_q1 [$];
  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];

  system_xbar i_dut (.*);

  for (genvar s = 0; s < NEXT_SLAVE; s++) begin : gen_mem
    tb_slave_model i_mem (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .req_i(slave_req_o[s]), .we_i(slave_we_o[s]), .be_i(slave_be_o[s]),
      .addr_i(slave_addr_o[s]), .wdata_i(slave_wdata_o[s]),
      .gnt_o(slave_gnt_i[s]), .rvalid_o(slave_rvalid_i[s]), .rdata_o(slave_rdata_i[s])
    );
  end

  always #4 clk_i = ~clk_i;

  function automatic int route(input logic [ADDR_W-1:0] a);
    for (int s = 0; s < NEXT_SLAVE; s++) begin
      if (a >= SLV_BASE[s] && a < SLV_BASE[s] + SLV_SIZE[s]) begin
        return s;
      end
    end
    return int'(ERROR_IDX);
  endfunction

  function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old,
                                             input logic [DATA_W-1:0] nw,
                                             input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic int pending(input int m);
    return (m == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  function automatic void push_exp(input int m, input logic [32:0] e);
    if (m == 0) begin
      exp_q0.push_back(e);
    end else begin
      exp_q1.push_back(e);
    end
  endfunction

  function automatic logic [32:0] pop_exp(input int m);
    return (m == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
  endfunction

  // Holds the request until granted, then records the expected response
  task automatic issue(input int m, input logic we, input logic [BE_W-1:0] be,
                       input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic [ADDR_W-1:0] key;
    logic [DATA_W-1:0] old;
    master_req_i[m]   <= 1'b1;
    master_we_i[m]    <= we;
    master_be_i[m]    <= be;
    master_addr_i[m]  <= addr;
    master_wdata_i[m] <= wdata;
    do @(posedge clk_i); while (!master_gnt_o[m]);
    key = {addr[ADDR_W-1:2], 2'b00};
    old = ref_mem.exists(key) ? ref_mem[key] : '0;
    if (route(addr) == int'(ERROR_IDX)) begin
      push_exp(m, {1'b1, ERR_RDATA});
    end else if (we) begin
      ref_mem[key] = merge(old, wdata, be);
      push_exp(m, {1'b0, 32'h0});
    end else begin
      push_exp(m, {1'b1, old});
    end
  endtask

  task automatic idle(input int m);
    master_req_i[m] <= 1'b0;
  endtask

  task automatic wait_idle(input int m);
    while (pending(m) != 0) begin
      @(posedge clk_i);
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
  endtask

  // Responses checked in issue order per master
  always @(posedge clk_i) begin
    logic [32:0] e;
    if (rst_n_i) begin
      for (int m = 0; m < NMASTER; m++) begin
        if (master_rvalid_o[m]) begin
          assert (pending(m) != 0) else begin
            errors++;
            $display("Error: master %0d got a response with nothing outstanding", m);
          end
          if (pending(m) != 0) begin
            e = pop_exp(m);
            if (e[32]) begin
              assert (master_rdata_o[m] == e[31:0]) else begin
                errors++;
                $display("FAILED %0t: master %0d read %h, expected %h",
                         $time, m, master_rdata_o[m], e[31:0]);
              end
            end
          end
        end
      end
    end
  end

  // Round-robin order and the quiet external side during error accesses
  always @(posedge clk_i) begin
    logic [NMASTER-1:0] want;
    if (!rst_n_i) begin
      for (int s = 0; s < NEXT_SLAVE; s++) begin
        last_win[s] = 1;
      end
    end else begin
      if (err_phase) begin
        assert (slave_req_o == '0) else begin
          errors++;
          $display("Error: external target requested during unmapped access");
        end
      end
      for (int s = 0; s < NEXT_SLAVE; s++) begin
        for (int m = 0; m < NMASTER; m++) begin
          want[m] = master_req_i[m] && route(master_addr_i[m]) == s;
        end
        if ((want & master_gnt_o) != '0) begin
          if (want == 2'b11) begin
            contended++;
            assert (!master_gnt_o[last_win[s]]) else begin
              errors++;
              $display("Error: target %0d granted master %0d twice in a row",
                       s, last_win[s]);
            end
          end
          last_win[s] = master_gnt_o[1] ? 1 : 0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    logic [ADDR_W-1:0] a;
    logic [BE_W-1:0]   be_mix;
    int                e0;
    int                total;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    master_req_i = '0;
    master_we_i = '0;
    master_be_i = '0;
    master_addr_i = '0;
    master_wdata_i = '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    e0 = errors;
    repeat (3) begin
      @(posedge clk_i);
      assert (master_gnt_o == '0 && master_rvalid_o == '0 && slave_req_o == '0) else begin
        errors++;
        $display("FAILED %0t: outputs active after reset", $time);
      end
    end
    report("reset_idle", e0);

    e0 = errors;
    for (int m = 0; m < NMASTER; m++) begin
      for (int s = 0; s < NEXT_SLAVE; s++) begin
        a = SLV_BASE[s] + 32'h40 + 32'(m * 8);
        be_mix = (s == 0) ? 4'h5 : (s == 1) ? 4'hA : 4'h6;
        issue(m, 1'b1, 4'hF, a, {8'(m), 8'(s), 16'hC0DE});
        issue(m, 1'b1, be_mix, a, {8'(s), 8'(m), 16'h3F21});
        issue(m, 1'b0, 4'hF, a, '0);
        idle(m);
        wait_idle(m);
      end
    end
    report("window_rw", e0);

    e0 = errors;
    err_phase = 1'b1;
    issue(0, 1'b0, 4'hF, 32'h4000_0000, '0);
    issue(0, 1'b1, 4'h3, 32'h0002_0000, 32'h1234_5678);
    idle(0);
    issue(1, 1'b0, 4'hF, 32'hFFFF_FFFC, '0);
    idle(1);
    wait_idle(0);
    wait_idle(1);
    err_phase = 1'b0;
    report("unmapped", e0);

    e0 = errors;
    contended = 0;
    fork
      begin
        repeat (6) issue(0, 1'b0, 4'hF, SLV_BASE[1] + 32'h40, '0);
        idle(0);
      end
      begin
        repeat (6) issue(1, 1'b0, 4'hF, SLV_BASE[1] + 32'h48, '0);
        idle(1);
      end
    join
    wait_idle(0);
    wait_idle(1);
    assert (contended > 0) else begin
      errors++;
      $display("Error: the two masters never competed for the RAM");
    end
    report("round_robin", e0);

    e0 = errors;
    fork
      begin
        for (int k = 0; k < MAX_OUTSTANDING; k++) begin
          issue(0, 1'b1, 4'hF, SLV_BASE[1] + 32'h200 + 32'(4 * k), 32'h5A5A_0000 ^ 32'(k));
        end
        for (int k = 0; k < MAX_OUTSTANDING; k++) begin
          issue(0, 1'b0, 4'hF, SLV_BASE[1] + 32'h200 + 32'(4 * k), '0);
        end
        idle(0);
      end
      begin
        for (int k = 0; k < MAX_OUTSTANDING; k++) begin
          issue(1, 1'b1, 4'hF, SLV_BASE[1] + 32'h300 + 32'(4 * k), 32'hA5A5_0100 ^ 32'(k));
        end
        for (int k = 0; k < MAX_OUTSTANDING; k++) begin
          issue(1, 1'b0, 4'hF, SLV_BASE[1] + 32'h300 + 32'(4 * k), '0);
        end
        idle(1);
      end
    join
    wait_idle(0);
    wait_idle(1);
    report("outstanding", e0);

    e0 = errors;
    fork
      begin
        issue(0, 1'b1, 4'hF, SLV_BASE[0] + 32'h80, 32'h0BAD_F00D);
        issue(0, 1'b0, 4'hF, SLV_BASE[0] + 32'h80, '0);
        issue(0, 1'b1, 4'h3, SLV_BASE[0] + 32'h80, 32'h7777_1234);
        issue(0, 1'b0, 4'hF, SLV_BASE[0] + 32'h80, '0);
        idle(0);
      end
      begin
        issue(1, 1'b1, 4'hF, SLV_BASE[2] + 32'h80, 32'hFACE_0042);
        issue(1, 1'b0, 4'hF, SLV_BASE[2] + 32'h80, '0);
        issue(1, 1'b1, 4'hC, SLV_BASE[2] + 32'h80, 32'h9999_8888);
        issue(1, 1'b0, 4'hF, SLV_BASE[2] + 32'h80, '0);
        idle(1);
      end
    join
    wait_idle(0);
    wait_idle(1);
    report("parallel", e0);

    total = errors + i_dut.i_sva.fail_cnt;
    $display("Tests run: %0d, checks failed: %0d", tests, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_system_xbar

`default_nettype wire

/* xbar_pkg.sv */
// ##############################
// Crossbar package: bus widths, port counts,
// address map and error response constants
// ##############################
`default_nettype none

package xbar_pkg;

  // Port counts
  localparam int unsigned NMASTER     = 2;
  localparam int unsigned NSLAVE      = 4;
  localparam int unsigned NEXT_SLAVE  = 3;
  localparam int unsigned LOG_NSLAVE  = 2;
  localparam int unsigned LOG_NMASTER = 1;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;

  // Internal error target sits above the external ones
  localparam int unsigned ERROR_IDX = 3;

  // Address map, index 0 is the boot ROM, 1 the RAM, 2 the peripherals
  localparam logic [NEXT_SLAVE-1:0][ADDR_W-1:0] SLV_BASE = {
    32'h2000_0000,
    32'h0001_0000,
    32'h0000_0000
  };
  localparam logic [NEXT_SLAVE-1:0][ADDR_W-1:0] SLV_SIZE = {
    32'h0000_1000,
    32'h0000_1000,
    32'h0000_1000
  };

  // Owner queue depth per target and its pointer width
  localparam int unsigned MAX_OUTSTANDING = 4;
  localparam int unsigned QPTR_W          = 2;

  // Read data of every error response
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hBADA_CCE5;

endpackage : xbar_pkg

`default_nettype wire

/* xbar_varlat.sv */
// ##############################
// Variable-latency crossbar: per-target arbitration,
// request muxing and in-order response routing
// ##############################
`default_nettype none

module xbar_varlat
  import xbar_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // Master side
  input  logic [NMASTER-1:0]                 req_i,
  input  logic [NMASTER-1:0][LOG_NSLAVE-1:0] sel_i,
  input  logic [NMASTER-1:0]                 we_i,
  input  logic [NMASTER-1:0][BE_W-1:0]       be_i,
  input  logic [NMASTER-1:0][ADDR_W-1:0]     addr_i,
  input  logic [NMASTER-1:0][DATA_W-1:0]     wdata_i,
  output logic [NMASTER-1:0]                 gnt_o,
  output logic [NMASTER-1:0]                 rvalid_o,
  output logic [NMASTER-1:0][DATA_W-1:0]     rdata_o,
  // Target side
  output logic [NSLAVE-1:0]                  req_o,
  output logic [NSLAVE-1:0]                  we_o,
  output logic [NSLAVE-1:0][BE_W-1:0]        be_o,
  output logic [NSLAVE-1:0][ADDR_W-1:0]      addr_o,
  output logic [NSLAVE-1:0][DATA_W-1:0]      wdata_o,
  input  logic [NSLAVE-1:0]                  gnt_i,
  input  logic [NSLAVE-1:0]                  rvalid_i,
  input  logic [NSLAVE-1:0][DATA_W-1:0]      rdata_i
);

  logic [NSLAVE-1:0][NMASTER-1:0]     cand_req;
  logic [NSLAVE-1:0][NMASTER-1:0]     win_oh;
  logic [NSLAVE-1:0][LOG_NMASTER-1:0] win_idx;
  logic [NSLAVE-1:0]                  xfer;
  logic [NSLAVE-1:0]                  q_full;
  logic [NSLAVE-1:0]                  q_empty;
  logic [NSLAVE-1:0][LOG_NMASTER-1:0] q_head;

  for (genvar s = 0; s < NSLAVE; s++) begin : gen_target
    // Owner queue, one master index per outstanding transfer
    logic [LOG_NMASTER-1:0] owner_mem [MAX_OUTSTANDING];
    logic [QPTR_W-1:0]      wr_ptr_q;
    logic [QPTR_W-1:0]      rd_ptr_q;
    logic [QPTR_W:0]        count_q;
    logic                   pop;

    // A full queue hides this target from every master
    for (genvar m = 0; m < NMASTER; m++) begin : gen_cand
      assign cand_req[s][m] = req_i[m] && (sel_i[m] == LOG_NSLAVE'(s)) && !q_full[s];
    end

    rr_arbiter i_arb (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_i      (cand_req[s]),
      .advance_i  (xfer[s]),
      .grant_o    (win_oh[s]),
      .grant_idx_o(win_idx[s])
    );

    // Winner's fields onto the target port
    assign req_o[s]   = |cand_req[s];
    assign we_o[s]    = we_i[win_idx[s]];
    assign be_o[s]    = be_i[win_idx[s]];
    assign addr_o[s]  = addr_i[win_idx[s]];
    assign wdata_o[s] = wdata_i[win_idx[s]];

    assign xfer[s]    = req_o[s] && gnt_i[s];
    assign pop        = rvalid_i[s] && !q_empty[s];
    assign q_full[s]  = (count_q == (QPTR_W + 1)'(MAX_OUTSTANDING));
    assign q_empty[s] = (count_q == '0);
    assign q_head[s]  = owner_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (xfer[s]) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        // Push and pop in one cycle leave the level unchanged
        case ({xfer[s], pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (xfer[s]) begin
        owner_mem[wr_ptr_q] <= win_idx[s];
      end
    end
  end

  // Target grant goes back to whichever master won there
  always_comb begin
    gnt_o = '0;
    for (int s = 0; s < NSLAVE; s++) begin
      for (int m = 0; m < NMASTER; m++) begin
        gnt_o[m] = gnt_o[m] | (win_oh[s][m] & gnt_i[s]);
      end
    end
  end

  // Responses follow the oldest recorded owner of each target
  always_comb begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int s = 0; s < NSLAVE; s++) begin
      if (rvalid_i[s] && !q_empty[s]) begin
        rvalid_o[q_head[s]] = 1'b1;
        rdata_o[q_head[s]]  = rdata_i[s];
      end
    end
  end

endmodule : xbar_varlat

`default_nettype wire
